// ==== cpu_pkg.sv ====
// Widths, opcodes, ALU and condition codes, stage codes, writeback selects, instruction union
package cpu_pkg;

  //--------------------------------------------------------------------
  // Widths
  //--------------------------------------------------------------------
  localparam int DATA_W     = 32;
  localparam int PC_W       = 25;
  localparam int ADDR_W     = 26;  // Word address on the memory port
  localparam int REG_ADDR_W = 4;
  localparam int ALU_OP_W   = 5;
  localparam int STAGE_W    = 3;

  localparam logic [REG_ADDR_W-1:0] LINK_REG = 4'd15;  // BAL return address

  // Unlisted ALU codes yield zero
  localparam logic [ALU_OP_W-1:0] ALU_SUB = 5'd0;
  localparam logic [ALU_OP_W-1:0] ALU_ADD = 5'd2;
  localparam logic [ALU_OP_W-1:0] ALU_XOR = 5'd4;
  localparam logic [ALU_OP_W-1:0] ALU_OR  = 5'd5;
  localparam logic [ALU_OP_W-1:0] ALU_AND = 5'd6;

  //--------------------------------------------------------------------
  // Opcodes and condition codes
  //--------------------------------------------------------------------
  localparam logic [5:0] OP_ALU   = 6'b00_0011;
  localparam logic [5:0] OP_JR    = 6'b00_1011;
  localparam logic [5:0] OP_B     = 6'b00_0001;
  localparam logic [5:0] OP_BAL   = 6'b00_1001;
  localparam logic [5:0] OP_LDW   = 6'b00_0010;
  localparam logic [5:0] OP_STW   = 6'b00_0110;
  localparam logic [5:0] OP_ADDIL = 6'b00_1010;
  localparam logic [5:0] OP_ADDIH = 6'b00_1110;
  localparam logic [5:0] OP_ORIL  = 6'b01_0010;
  localparam logic [5:0] OP_ORIH  = 6'b01_0110;
  localparam logic [5:0] OP_ANDIL = 6'b01_1010;
  localparam logic [5:0] OP_ANDIH = 6'b01_1110;

  localparam logic [3:0] COND_EQ = 4'h0;  // Z
  localparam logic [3:0] COND_NE = 4'h1;
  localparam logic [3:0] COND_HS = 4'h2;  // C
  localparam logic [3:0] COND_LO = 4'h3;
  localparam logic [3:0] COND_MI = 4'h4;  // N
  localparam logic [3:0] COND_PL = 4'h5;
  localparam logic [3:0] COND_VS = 4'h6;  // V
  localparam logic [3:0] COND_VC = 4'h7;
  localparam logic [3:0] COND_HI = 4'h8;
  localparam logic [3:0] COND_LS = 4'h9;
  localparam logic [3:0] COND_GE = 4'ha;
  localparam logic [3:0] COND_LT = 4'hb;
  localparam logic [3:0] COND_GT = 4'hc;
  localparam logic [3:0] COND_LE = 4'hd;
  localparam logic [3:0] COND_AL = 4'he;
  localparam logic [3:0] COND_NV = 4'hf;

  //--------------------------------------------------------------------
  // Sequencer stages and writeback sources
  //--------------------------------------------------------------------
  localparam logic [STAGE_W-1:0] STAGE_FETCH     = 3'd1;
  localparam logic [STAGE_W-1:0] STAGE_DECODE    = 3'd2;
  localparam logic [STAGE_W-1:0] STAGE_EXEC      = 3'd3;
  localparam logic [STAGE_W-1:0] STAGE_ACCESS    = 3'd4;
  localparam logic [STAGE_W-1:0] STAGE_WRITEBACK = 3'd5;
  localparam logic [STAGE_W-1:0] STAGE_MEM_WAIT  = 3'd6;

  localparam logic [1:0] WB_SEL_ALU  = 2'd0;
  localparam logic [1:0] WB_SEL_MEM  = 2'd1;
  localparam logic [1:0] WB_SEL_LINK = 2'd2;

  // Instruction word, register and immediate layouts
  typedef union packed {
    struct packed {
      logic [5:0]            opcode;
      logic [3:0]            cond;
      logic                  set_flags;
      logic [REG_ADDR_W-1:0] src_a;
      logic [REG_ADDR_W-1:0] src_b;
      logic [REG_ADDR_W-1:0] dest;
      logic [ALU_OP_W-1:0]   alu_op;
      logic [3:0]            spare;
    } reg_fmt;
    struct packed {
      logic [5:0]            opcode;
      logic [REG_ADDR_W-1:0] base;
      logic                  set_flags;
      logic [REG_ADDR_W-1:0] reg_field;
      logic                  spare;
      logic [15:0]           imm16;
    } imm_fmt;
  } instr_t;

endpackage

// ==== fetch_unit.sv ====
// Program counter, instruction register and return-address capture
module fetch_unit import cpu_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              pc_enable,
  input  logic              ir_enable,
  input  logic              jump_sel,
  input  logic              offset_sel,
  input  logic [DATA_W-1:0] immediate,
  input  logic [DATA_W-1:0] operand_a,
  input  logic [DATA_W-1:0] memory_data_read,
  output instr_t            instr,
  output logic [PC_W-1:0]   pc,
  output logic [PC_W-1:0]   link_addr
);

  logic [PC_W-1:0] step;
  logic [PC_W-1:0] pc_next;
  logic [PC_W-1:0] ret_pc;  // pc of the instruction that moved it

  // Branch offset is imm16 sign-extended to the pc width
  assign step = offset_sel ? {{(PC_W-16){immediate[15]}}, immediate[15:0]} : PC_W'(1);

  assign pc_next = jump_sel ? operand_a[PC_W-1:0] : pc + step;

  assign link_addr = ret_pc + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= '0;
      ret_pc <= '0;
      instr  <= '0;
    end else begin
      if (pc_enable) begin
        pc     <= pc_next;
        ret_pc <= pc;
      end
      if (ir_enable) instr <= memory_data_read;  // Fetch data held by memory
    end
  end

endmodule

// ==== stage_sequencer.sv ====
// Stage FSM and per-stage decode of the control strobes
module stage_sequencer import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  instr_t                instr,
  input  logic                  status_pass,
  input  logic                  memory_busy,
  output logic                  memory_read_req,
  output logic                  memory_write_req,
  output logic [REG_ADDR_W-1:0] read_addr_a,
  output logic [REG_ADDR_W-1:0] read_addr_b,
  output logic [REG_ADDR_W-1:0] write_addr,
  output logic                  write_enable,
  output logic [ALU_OP_W-1:0]   alu_op,
  output logic                  operand_sel_imm,
  output logic [DATA_W-1:0]     immediate,
  output logic                  flag_update,
  output logic                  cond_latch,
  output logic                  pc_enable,
  output logic                  ir_enable,
  output logic                  jump_sel,
  output logic                  offset_sel,
  output logic                  addr_sel,
  output logic [1:0]            result_sel
);

  logic [STAGE_W-1:0] stage;
  logic [STAGE_W-1:0] stage_next;
  logic [5:0]         opcode;
  logic [15:0]        imm16;
  logic [DATA_W-1:0]  imm_next;

  assign opcode = instr.reg_fmt.opcode;
  assign imm16  = instr.imm_fmt.imm16;  // Branches also read this view

  //--------------------------------------------------------------------
  // Immediate forms
  //--------------------------------------------------------------------
  always_comb begin
    case (opcode)
      OP_ADDIL, OP_B, OP_BAL, OP_LDW, OP_STW:
        imm_next = {{(DATA_W-16){imm16[15]}}, imm16};
      OP_ADDIH, OP_ORIH: imm_next = {imm16, {(DATA_W-16){1'b0}}};
      OP_ORIL:           imm_next = {{(DATA_W-16){1'b0}}, imm16};
      OP_ANDIL:          imm_next = {{(DATA_W-16){1'b1}}, imm16};  // Keep upper half
      OP_ANDIH:          imm_next = {imm16, {(DATA_W-16){1'b1}}};
      default:           imm_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cond_latch) immediate <= imm_next;  // Valid from EXEC on
  end

  always_ff @(posedge clk) begin
    if (reset) stage <= STAGE_WRITEBACK;  // Comes out of reset fetching address 0
    else       stage <= stage_next;
  end

  //--------------------------------------------------------------------
  // Stage decode
  //--------------------------------------------------------------------
  always_comb begin
    stage_next       = stage;
    memory_read_req  = 1'b0;
    memory_write_req = 1'b0;
    read_addr_a      = '0;
    read_addr_b      = '0;
    write_addr       = '0;
    write_enable     = 1'b0;
    alu_op           = ALU_SUB;
    operand_sel_imm  = 1'b0;
    flag_update      = 1'b0;
    cond_latch       = 1'b0;
    pc_enable        = 1'b0;
    ir_enable        = 1'b0;
    jump_sel         = 1'b0;
    offset_sel       = 1'b0;
    addr_sel         = 1'b0;
    result_sel       = WB_SEL_ALU;
    if (!reset) begin
      case (stage)
        STAGE_FETCH: begin
          if (!memory_busy) begin
            ir_enable  = 1'b1;
            stage_next = STAGE_DECODE;
          end
        end
        STAGE_DECODE: begin
          stage_next = STAGE_EXEC;
          cond_latch = 1'b1;
          case (opcode)
            OP_ALU, OP_JR: begin
              read_addr_a = instr.reg_fmt.src_a;
              read_addr_b = instr.reg_fmt.src_b;
            end
            OP_STW: begin
              read_addr_a = instr.imm_fmt.base;
              read_addr_b = instr.imm_fmt.reg_field;  // Store data
            end
            OP_LDW, OP_ADDIL, OP_ADDIH, OP_ORIL, OP_ORIH, OP_ANDIL, OP_ANDIH:
              read_addr_a = instr.imm_fmt.base;
            default: ;
          endcase
        end
        STAGE_EXEC: begin
          stage_next  = STAGE_ACCESS;
          pc_enable   = 1'b1;
          flag_update = instr.reg_fmt.set_flags;
          case (opcode)
            OP_ALU:       alu_op = instr.reg_fmt.alu_op;
            OP_JR:        jump_sel = status_pass;
            OP_B, OP_BAL: offset_sel = status_pass;
            OP_LDW, OP_STW, OP_ADDIL, OP_ADDIH: begin
              operand_sel_imm = 1'b1;
              alu_op          = ALU_ADD;
            end
            OP_ORIL, OP_ORIH: begin
              operand_sel_imm = 1'b1;
              alu_op          = ALU_OR;
            end
            OP_ANDIL, OP_ANDIH: begin
              operand_sel_imm = 1'b1;
              alu_op          = ALU_AND;
            end
            default: ;
          endcase
        end
        STAGE_ACCESS: begin
          stage_next = STAGE_WRITEBACK;
          case (opcode)
            OP_BAL: result_sel = WB_SEL_LINK;
            OP_LDW: begin
              memory_read_req = 1'b1;
              stage_next      = STAGE_MEM_WAIT;
            end
            OP_STW: begin
              memory_write_req = 1'b1;
              stage_next       = STAGE_MEM_WAIT;
            end
            default: ;
          endcase
        end
        STAGE_MEM_WAIT: begin
          if (!memory_busy) begin
            result_sel = WB_SEL_MEM;
            stage_next = STAGE_WRITEBACK;
          end
        end
        STAGE_WRITEBACK: begin
          stage_next      = STAGE_FETCH;
          memory_read_req = 1'b1;  // Next instruction at the new pc
          addr_sel        = 1'b1;
          case (opcode)
            OP_ALU: begin
              write_enable = status_pass;
              write_addr   = instr.reg_fmt.dest;
            end
            OP_BAL: begin
              write_enable = status_pass;
              write_addr   = LINK_REG;
            end
            OP_LDW, OP_ADDIL, OP_ADDIH, OP_ORIL, OP_ORIH, OP_ANDIL, OP_ANDIH: begin
              write_enable = 1'b1;
              write_addr   = instr.imm_fmt.reg_field;
            end
            default: ;
          endcase
        end
        default: stage_next = STAGE_WRITEBACK;
      endcase
    end
  end

endmodule

// ==== register_file.sv ====
// Fifteen working registers, zero register at index 0, registered read ports
module register_file import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [REG_ADDR_W-1:0] read_addr_a,
  input  logic [REG_ADDR_W-1:0] read_addr_b,
  input  logic [REG_ADDR_W-1:0] write_addr,
  input  logic                  write_enable,
  input  logic [DATA_W-1:0]     writeback_data,
  output logic [DATA_W-1:0]     operand_a,
  output logic [DATA_W-1:0]     operand_b
);

  logic [DATA_W-1:0] regs [1:2**REG_ADDR_W-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 2**REG_ADDR_W; i++) regs[i] <= '0;
      operand_a <= '0;
      operand_b <= '0;
    end else begin
      if (write_enable && write_addr != '0) regs[write_addr] <= writeback_data;
      // Index 0 reads as zero
      operand_a <= (read_addr_a == '0) ? '0 : regs[read_addr_a];
      operand_b <= (read_addr_b == '0) ? '0 : regs[read_addr_b];
    end
  end

endmodule

// ==== alu_flags.sv ====
// ALU, result register, NZCV flags and condition evaluation
module alu_flags import cpu_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [DATA_W-1:0]   operand_a,
  input  logic [DATA_W-1:0]   operand_b,
  input  logic [DATA_W-1:0]   immediate,
  input  logic                operand_sel_imm,
  input  logic [ALU_OP_W-1:0] alu_op,
  input  logic                flag_update,
  input  logic                cond_latch,
  input  instr_t              instr,
  output logic [DATA_W-1:0]   result,
  output logic                status_pass
);

  localparam int MSB = DATA_W - 1;

  logic [DATA_W-1:0] alu_b;
  logic [DATA_W:0]   alu_out;  // Carry in the top bit
  logic              c_next;
  logic              v_next;
  logic              n_flag;
  logic              z_flag;
  logic              c_flag;
  logic              v_flag;
  logic              cond_true;

  assign alu_b = operand_sel_imm ? immediate : operand_b;

  always_comb begin
    alu_out = '0;
    c_next  = 1'b0;
    v_next  = 1'b0;
    case (alu_op)
      ALU_ADD: begin
        alu_out = {1'b0, operand_a} + {1'b0, alu_b};
        c_next  = alu_out[DATA_W];
        v_next  = (operand_a[MSB] == alu_b[MSB]) && (alu_out[MSB] != operand_a[MSB]);
      end
      ALU_SUB: begin
        alu_out = {1'b0, operand_a} - {1'b0, alu_b};
        c_next  = ~alu_out[DATA_W];  // Set when no borrow
        v_next  = (operand_a[MSB] != alu_b[MSB]) && (alu_out[MSB] != operand_a[MSB]);
      end
      ALU_AND: alu_out = {1'b0, operand_a & alu_b};
      ALU_OR:  alu_out = {1'b0, operand_a | alu_b};
      ALU_XOR: alu_out = {1'b0, operand_a ^ alu_b};
      default: alu_out = '0;
    endcase
  end

  // Condition field of the current instruction against the held flags
  always_comb begin
    case (instr.reg_fmt.cond)
      COND_EQ: cond_true = z_flag;
      COND_NE: cond_true = ~z_flag;
      COND_HS: cond_true = c_flag;
      COND_LO: cond_true = ~c_flag;
      COND_MI: cond_true = n_flag;
      COND_PL: cond_true = ~n_flag;
      COND_VS: cond_true = v_flag;
      COND_VC: cond_true = ~v_flag;
      COND_HI: cond_true = c_flag & ~z_flag;
      COND_LS: cond_true = ~c_flag | z_flag;
      COND_GE: cond_true = (n_flag == v_flag);
      COND_LT: cond_true = (n_flag != v_flag);
      COND_GT: cond_true = ~z_flag & (n_flag == v_flag);
      COND_LE: cond_true = z_flag | (n_flag != v_flag);
      COND_AL: cond_true = 1'b1;
      COND_NV: cond_true = 1'b0;
      default: cond_true = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    result <= alu_out[MSB:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      n_flag      <= 1'b0;
      z_flag      <= 1'b0;
      c_flag      <= 1'b0;
      v_flag      <= 1'b0;
      status_pass <= 1'b1;
    end else begin
      if (flag_update) begin
        n_flag <= alu_out[MSB];
        z_flag <= (alu_out[MSB:0] == '0);
        c_flag <= c_next;
        v_flag <= v_next;
      end
      if (cond_latch) status_pass <= cond_true;  // Held for the rest of the instruction
    end
  end

endmodule

// ==== memory_port.sv ====
// Memory address mux, store data register and writeback select
module memory_port import cpu_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [DATA_W-1:0] result,
  input  logic [PC_W-1:0]   pc,
  input  logic [PC_W-1:0]   link_addr,
  input  logic [DATA_W-1:0] operand_b,
  input  logic [DATA_W-1:0] memory_data_read,
  input  logic              addr_sel,
  input  logic [1:0]        result_sel,
  output logic [ADDR_W-1:0] memory_addr,
  output logic [DATA_W-1:0] memory_data_write,
  output logic [DATA_W-1:0] writeback_data
);

  // Data access uses the ALU result and fetch uses the pc
  assign memory_addr = addr_sel ? {{(ADDR_W-PC_W){1'b0}}, pc} : result[ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      memory_data_write <= '0;
      writeback_data    <= '0;
    end else begin
      memory_data_write <= operand_b;  // Valid in ACCESS for STW
      case (result_sel)
        WB_SEL_MEM:  writeback_data <= memory_data_read;
        WB_SEL_LINK: writeback_data <= {{(DATA_W-PC_W){1'b0}}, link_addr};
        default:     writeback_data <= result;
      endcase
    end
  end

endmodule

// ==== cpu_core.sv ====
// Top level of the multi-cycle core that connects fetch, sequencer, registers, ALU and memory port
module cpu_core import cpu_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [DATA_W-1:0] memory_data_read,
  input  logic              memory_busy,
  output logic              memory_read_req,
  output logic              memory_write_req,
  output logic [ADDR_W-1:0] memory_addr,
  output logic [DATA_W-1:0] memory_data_write
);

  instr_t                instr;
  logic [PC_W-1:0]       pc;
  logic [PC_W-1:0]       link_addr;
  logic [DATA_W-1:0]     operand_a;
  logic [DATA_W-1:0]     operand_b;
  logic [DATA_W-1:0]     result;
  logic [DATA_W-1:0]     writeback_data;
  logic [DATA_W-1:0]     immediate;
  logic                  status_pass;
  logic [REG_ADDR_W-1:0] read_addr_a;
  logic [REG_ADDR_W-1:0] read_addr_b;
  logic [REG_ADDR_W-1:0] write_addr;
  logic                  write_enable;
  logic [ALU_OP_W-1:0]   alu_op;
  logic                  operand_sel_imm;
  logic                  flag_update;
  logic                  cond_latch;
  logic                  pc_enable;
  logic                  ir_enable;
  logic                  jump_sel;
  logic                  offset_sel;
  logic                  addr_sel;
  logic [1:0]            result_sel;

  //--------------------------------------------------------------------
  // Input side and control
  //--------------------------------------------------------------------
  fetch_unit u_fetch (
    .clk              (clk),
    .reset            (reset),
    .pc_enable        (pc_enable),
    .ir_enable        (ir_enable),
    .jump_sel         (jump_sel),
    .offset_sel       (offset_sel),
    .immediate        (immediate),
    .operand_a        (operand_a),
    .memory_data_read (memory_data_read),
    .instr            (instr),
    .pc               (pc),
    .link_addr        (link_addr)
  );

  stage_sequencer u_seq (
    .clk              (clk),
    .reset            (reset),
    .instr            (instr),
    .status_pass      (status_pass),
    .memory_busy      (memory_busy),
    .memory_read_req  (memory_read_req),
    .memory_write_req (memory_write_req),
    .read_addr_a      (read_addr_a),
    .read_addr_b      (read_addr_b),
    .write_addr       (write_addr),
    .write_enable     (write_enable),
    .alu_op           (alu_op),
    .operand_sel_imm  (operand_sel_imm),
    .immediate        (immediate),
    .flag_update      (flag_update),
    .cond_latch       (cond_latch),
    .pc_enable        (pc_enable),
    .ir_enable        (ir_enable),
    .jump_sel         (jump_sel),
    .offset_sel       (offset_sel),
    .addr_sel         (addr_sel),
    .result_sel       (result_sel)
  );

  //--------------------------------------------------------------------
  // Datapath and output side
  //--------------------------------------------------------------------
  register_file u_regs (
    .clk            (clk),
    .reset          (reset),
    .read_addr_a    (read_addr_a),
    .read_addr_b    (read_addr_b),
    .write_addr     (write_addr),
    .write_enable   (write_enable),
    .writeback_data (writeback_data),
    .operand_a      (operand_a),
    .operand_b      (operand_b)
  );

  alu_flags u_alu (
    .clk             (clk),
    .reset           (reset),
    .operand_a       (operand_a),
    .operand_b       (operand_b),
    .immediate       (immediate),
    .operand_sel_imm (operand_sel_imm),
    .alu_op          (alu_op),
    .flag_update     (flag_update),
    .cond_latch      (cond_latch),
    .instr           (instr),
    .result          (result),
    .status_pass     (status_pass)
  );

  memory_port u_mem (
    .clk               (clk),
    .reset             (reset),
    .result            (result),
    .pc                (pc),
    .link_addr         (link_addr),
    .operand_b         (operand_b),
    .memory_data_read  (memory_data_read),
    .addr_sel          (addr_sel),
    .result_sel        (result_sel),
    .memory_addr       (memory_addr),
    .memory_data_write (memory_data_write),
    .writeback_data    (writeback_data)
  );

endmodule

// ==== cpu_properties.sv ====
// Concurrent checks on the memory request pulses and their bind into the core
module cpu_properties (
  input logic clk,
  input logic reset,
  input logic memory_read_req,
  input logic memory_write_req,
  input logic memory_busy
);

  int   violation_count = 0;  // Failed assertions so far
  logic any_req;

  assign any_req = memory_read_req | memory_write_req;

  one_direction: assert property (@(posedge clk) disable iff (reset)
    !(memory_read_req && memory_write_req))
    else begin
      violation_count++;
      $error("read and write requests high in the same cycle");
    end

  // Requests are single-cycle pulses
  single_cycle_req: assert property (@(posedge clk) disable iff (reset)
    any_req |=> !any_req)
    else begin
      violation_count++;
      $error("memory request held for two cycles");
    end

  idle_while_busy: assert property (@(posedge clk) disable iff (reset)
    memory_busy |-> !any_req)
    else begin
      violation_count++;
      $error("memory request issued while busy");
    end

endmodule

bind cpu_core cpu_properties u_props (
  .clk              (clk),
  .reset            (reset),
  .memory_read_req  (memory_read_req),
  .memory_write_req (memory_write_req),
  .memory_busy      (memory_busy)
);

// ==== cpu_tb.sv ====
// Testbench with clock, reset, memory model with random busy, program table and checks
module cpu_tb import cpu_pkg::*; ();

  localparam int NUM_TESTS    = 8;
  localparam int PROG_WORDS   = 8;
  localparam int MEM_WORDS    = 64;
  localparam int DATA_ADDR    = 40;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT      = 2000;  // Cycles allowed per program

  logic              clk;
  logic              reset;
  logic [DATA_W-1:0] memory_data_read;
  logic              memory_busy;
  logic              memory_read_req;
  logic              memory_write_req;
  logic [ADDR_W-1:0] memory_addr;
  logic [DATA_W-1:0] memory_data_write;

  // Program table
  string       test_name   [NUM_TESTS];
  logic [31:0] program_rom [NUM_TESTS][PROG_WORDS];
  logic [31:0] data_word   [NUM_TESTS];
  logic [31:0] exp_addr    [NUM_TESTS];
  logic [31:0] exp_data    [NUM_TESTS];

  // Memory model state
  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic              req_rd;
  logic              req_wr;
  logic              req_reset;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_data;
  logic [DATA_W-1:0] read_word;
  logic              read_pending;
  int                busy_left;
  logic [31:0]       rng_state;
  logic              write_seen;  // First store since reset
  logic [31:0]       seen_addr;
  logic [31:0]       seen_data;
  int                test_idx;

  cpu_core uut (
    .clk               (clk),
    .reset             (reset),
    .memory_data_read  (memory_data_read),
    .memory_busy       (memory_busy),
    .memory_read_req   (memory_read_req),
    .memory_write_req  (memory_write_req),
    .memory_addr       (memory_addr),
    .memory_data_write (memory_data_write)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //--------------------------------------------------------------------
  // Instruction encoding and random numbers
  //--------------------------------------------------------------------
  function automatic logic [31:0] imm_word(logic [5:0] op, logic [3:0] base, logic [3:0] rd,
                                           logic [15:0] imm);
    return {op, base, 1'b0, rd, 1'b0, imm};
  endfunction

  function automatic logic [31:0] alu_word(logic [3:0] cond, logic set, logic [3:0] src_a,
                                           logic [3:0] src_b, logic [3:0] dest,
                                           logic [4:0] op);
    return {OP_ALU, cond, set, src_a, src_b, dest, op, 4'h0};
  endfunction

  function automatic logic [31:0] branch_word(logic [5:0] op, logic [3:0] cond,
                                              logic [15:0] offset);
    return {op, cond, 6'h00, offset};  // Offset counts from the branch itself
  endfunction

  function automatic logic [31:0] jr_word(logic [3:0] cond, logic [3:0] src);
    return {OP_JR, cond, 1'b0, src, 17'h0};
  endfunction

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //--------------------------------------------------------------------
  // Failure reporting and checks
  //--------------------------------------------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      stop_with_failure($sformatf("error %s: expected %08h, actual %08h",
                                  name, expected, actual));
  endtask

  task automatic set_row(input int idx, input string name, input logic [31:0] data,
                         input logic [31:0] addr, input logic [31:0] value);
    test_name[idx] = name;
    data_word[idx] = data;
    exp_addr[idx]  = addr;
    exp_data[idx]  = value;
  endtask

  task automatic build_table();
    // r1 built step by step and stored at 48 + 2
    set_row(0, "immediate_build", 32'h0000_0000, 32'd50, 32'h1033_8705);
    program_rom[0] = '{imm_word(OP_ADDIL, 4'd0, 4'd1, 16'h8765),  // ffff8765
                       imm_word(OP_ADDIH, 4'd1, 4'd1, 16'h1234),  // 12338765
                       imm_word(OP_ORIL,  4'd1, 4'd1, 16'h00f0),  // 123387f5
                       imm_word(OP_ORIH,  4'd1, 4'd1, 16'h0c00),  // 1e3387f5
                       imm_word(OP_ANDIL, 4'd1, 4'd1, 16'hff0f),  // 1e338705
                       imm_word(OP_ANDIH, 4'd1, 4'd1, 16'hf0ff),  // 10338705
                       imm_word(OP_ADDIL, 4'd0, 4'd2, 16'd48),
                       imm_word(OP_STW,   4'd2, 4'd1, 16'd2)};
    set_row(1, "register_alu", 32'h1111_2222, 32'd52, 32'hffff_fff8);
    program_rom[1] = '{imm_word(OP_ADDIL, 4'd0, 4'd1, 16'd100),
                       imm_word(OP_ADDIL, 4'd0, 4'd2, 16'd250),
                       alu_word(COND_AL, 1'b0, 4'd1, 4'd2, 4'd3, ALU_SUB),  // -150
                       alu_word(COND_AL, 1'b0, 4'd3, 4'd1, 4'd4, ALU_XOR),  // ffffff0e
                       alu_word(COND_AL, 1'b0, 4'd4, 4'd2, 4'd5, ALU_ADD),  // Wraps to 8
                       alu_word(COND_AL, 1'b0, 4'd0, 4'd5, 4'd6, ALU_SUB),  // 0 - 8
                       imm_word(OP_STW, 4'd0, 4'd6, 16'd52),
                       32'h0};
    // Equal operands make NE fall through and EQ skip the overwrite
    set_row(2, "branch_eq_ne", 32'h3333_4444, 32'd56, 32'h0000_0077);
    program_rom[2] = '{imm_word(OP_ADDIL, 4'd0, 4'd1, 16'h0077),
                       alu_word(COND_AL, 1'b1, 4'd1, 4'd1, 4'd3, ALU_SUB),
                       branch_word(OP_B, COND_NE, 16'd4),
                       branch_word(OP_B, COND_EQ, 16'd2),
                       imm_word(OP_ADDIL, 4'd0, 4'd1, 16'h0bad),
                       imm_word(OP_STW, 4'd0, 4'd1, 16'd56),
                       imm_word(OP_STW, 4'd0, 4'd0, 16'd57),  // Wrong path
                       32'h0};
    // 0 - 5 gives N set and V clear
    set_row(3, "branch_gt_lt", 32'h5555_6666, 32'd58, 32'hffff_fffb);
    program_rom[3] = '{imm_word(OP_ADDIL, 4'd0, 4'd1, 16'd5),
                       alu_word(COND_AL, 1'b1, 4'd0, 4'd1, 4'd3, ALU_SUB),
                       branch_word(OP_B, COND_GT, 16'd4),
                       branch_word(OP_B, COND_LT, 16'd2),
                       imm_word(OP_ADDIL, 4'd0, 4'd3, 16'h0bad),
                       imm_word(OP_STW, 4'd0, 4'd3, 16'd58),
                       imm_word(OP_STW, 4'd0, 4'd0, 16'd59),
                       32'h0};
    // Subroutine moves the base to 44 and the return lands on the store
    set_row(4, "link_return", 32'h7777_8888, 32'd44, 32'h0000_0002);
    program_rom[4] = '{imm_word(OP_ADDIL, 4'd0, 4'd2, 16'd40),
                       branch_word(OP_BAL, COND_AL, 16'd3),
                       imm_word(OP_STW, 4'd2, 4'd15, 16'd0),
                       32'h0,
                       imm_word(OP_ADDIL, 4'd2, 4'd2, 16'd4),
                       jr_word(COND_AL, 4'd15),
                       imm_word(OP_STW, 4'd0, 4'd0, 16'd45),
                       32'h0};
    set_row(5, "load_store_busy", 32'ha5c3_0f96, 32'd41, 32'ha5c3_0f96);
    program_rom[5] = '{imm_word(OP_ADDIL, 4'd0, 4'd2, 16'd32),
                       imm_word(OP_LDW, 4'd2, 4'd4, 16'd8),
                       imm_word(OP_STW, 4'd2, 4'd4, 16'd9),
                       32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
    set_row(6, "load_store_busy_again", 32'h3c5a_9617, 32'd41, 32'h3c5a_9617);
    program_rom[6] = program_rom[5];
    set_row(7, "cond_never", 32'h9999_aaaa, 32'd46, 32'h0000_1234);
    program_rom[7] = '{imm_word(OP_ADDIL, 4'd0, 4'd5, 16'h1234),
                       imm_word(OP_ADDIL, 4'd0, 4'd6, 16'h0100),
                       alu_word(COND_NV, 1'b0, 4'd5, 4'd6, 4'd5, ALU_ADD),
                       imm_word(OP_STW, 4'd0, 4'd5, 16'd46),
                       32'h0, 32'h0, 32'h0, 32'h0};
  endtask

  //--------------------------------------------------------------------
  // Per-row sequence
  //--------------------------------------------------------------------
  task automatic reset_and_load(input int t);
    int i;
    @(posedge clk);
    #1;
    reset = 1'b1;
    for (i = 0; i < RESET_CYCLES; i++) @(posedge clk);
    // Fill words decode as no-ops
    for (i = 0; i < MEM_WORDS; i++) mem[i] = 32'hfc00_0000 | (i * 32'h0101_0101);
    for (i = 0; i < PROG_WORDS; i++) mem[i] = program_rom[t][i];
    mem[DATA_ADDR] = data_word[t];
    write_seen     = 1'b0;
    #1;
    reset = 1'b0;
  endtask

  task automatic run_test(input int t);
    int cycles;
    reset_and_load(t);
    cycles = 0;
    while (!write_seen && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!write_seen)
      stop_with_failure($sformatf("test %s issued no store within %0d cycles",
                                  test_name[t], TIMEOUT));
    check_value({test_name[t], " address"}, exp_addr[t], seen_addr);
    check_value({test_name[t], " data"}, exp_data[t], seen_data);
    check_value({test_name[t], " assertions"}, 32'd0, uut.u_props.violation_count);
  endtask

  // Memory model samples mid-cycle and answers just after the edge
  always begin
    @(negedge clk);
    req_rd    = memory_read_req;
    req_wr    = memory_write_req;
    req_reset = reset;
    req_addr  = memory_addr;
    req_data  = memory_data_write;
    @(posedge clk);
    #1;
    if (req_reset) begin
      busy_left   = 0;
      memory_busy = 1'b0;
    end else if (req_rd || req_wr) begin
      if (req_wr) begin
        mem[req_addr[5:0]] = req_data;
        if (!write_seen) begin
          write_seen = 1'b1;
          seen_addr  = 32'(req_addr);
          seen_data  = req_data;
        end
      end
      read_pending = req_rd;
      if (req_rd) read_word = mem[req_addr[5:0]];
      rng_state   = xorshift(rng_state);
      busy_left   = int'(rng_state[1:0]);  // 0 to 3 busy cycles
      memory_busy = (busy_left != 0);
      if (busy_left == 0 && req_rd) memory_data_read = read_word;
    end else if (busy_left != 0) begin
      busy_left = busy_left - 1;
      if (busy_left == 0) begin
        memory_busy = 1'b0;
        if (read_pending) memory_data_read = read_word;
      end
    end
  end

  initial begin
    reset            = 1'b1;
    memory_busy      = 1'b0;
    memory_data_read = '0;
    write_seen       = 1'b0;
    read_pending     = 1'b0;
    busy_left        = 0;
    rng_state        = 32'hb9c9;
    build_table();
    for (test_idx = 0; test_idx < NUM_TESTS; test_idx++) run_test(test_idx);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== list.f ====
cpu_pkg.sv
fetch_unit.sv
stage_sequencer.sv
register_file.sv
alu_flags.sv
memory_port.sv
cpu_core.sv
cpu_properties.sv
cpu_tb.sv
